//--- hw/mem_pkg.sv
package mem_pkg;

        // Store geometry.
        localparam int MEM_BYTES = 8192;
        localparam int MEM_AW    = 13;

        // Port widths.
        localparam int ADDR_W = 32;
        localparam int DATA_W = 32;

        // CPSR mode code for user mode.
        localparam logic [4:0] MODE_USR = 5'b10000;

        // Configuration register map.
        localparam logic [1:0] CFG_CTRL   = 2'd0;
        localparam logic [1:0] CFG_LIMIT  = 2'd1;
        localparam logic [1:0] CFG_THRESH = 2'd2;
        localparam logic [1:0] CFG_SEED   = 2'd3;

        // Stall generator LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1.
        localparam int LFSR_W = 16;

        // Reset defaults.
        localparam logic [LFSR_W-1:0] DEFAULT_SEED  = 16'hACE1;
        localparam logic [MEM_AW-1:0] DEFAULT_LIMIT = 13'h0400;

        // Data port request.
        typedef struct packed {
                logic [ADDR_W-1:0] addr;
                logic [DATA_W-1:0] wdata;
                logic              rd_en;
                logic              wr_en;
        } data_req_t;

        // Settings for the guard and the stall generator.
        typedef struct packed {
                logic              stall_en;
                logic [MEM_AW-1:0] prot_limit;
                logic [7:0]        miss_thresh;
                logic [7:0]        imiss_thresh;
                logic [LFSR_W-1:0] seed;
                logic              seed_load;    // One cycle after a SEED write.
        } mem_cfg_t;

endpackage

//--- hw/unified_ram.sv
`timescale 1ns/1ps

module unified_ram
        import mem_pkg::*;
(
        input  logic              i_clk,

        // Data port.
        input  logic              i_we,
        input  logic [MEM_AW-1:0] i_daddr,
        input  logic [31:0]       i_wdata,
        input  logic              i_rd_en,

        // Instruction port.
        input  logic [MEM_AW-1:0] i_iaddr,

        output logic [31:0]       o_rdata,
        output logic [31:0]       o_idata
);

        // 8 KB unified byte store.
        logic [7:0] mem [MEM_BYTES];

        // Little-endian word write at any byte alignment.
        always_ff @(posedge i_clk)
        begin
                if (i_we)
                begin
                        for (int b = 0; b < 4; b++)
                        begin
                                mem[i_daddr + MEM_AW'(b)] <= i_wdata[8*b +: 8];
                        end
                end
        end

        // Data read is zero when the port is idle.
        always_comb
        begin
                o_rdata = '0;
                if (i_rd_en)
                begin
                        for (int b = 0; b < 4; b++)
                        begin
                                o_rdata[8*b +: 8] = mem[i_daddr + MEM_AW'(b)];
                        end
                end
        end

        // Instruction read is always live.
        always_comb
        begin
                o_idata = '0;
                for (int b = 0; b < 4; b++)
                begin
                        o_idata[8*b +: 8] = mem[i_iaddr + MEM_AW'(b)];
                end
        end

endmodule

//--- hw/access_guard.sv
`timescale 1ns/1ps

module access_guard
        import mem_pkg::*;
(
        input  data_req_t         i_dreq,
        input  logic [ADDR_W-1:0] i_iaddr,
        input  logic [4:0]        i_cpsr_mode,
        input  mem_cfg_t          i_cfg,

        output logic              o_dabort,     // Data abort.
        output logic              o_iabort      // Instruction abort.
);

        // Highest address where a full word still fits.
        localparam logic [ADDR_W-1:0] LAST_WORD = ADDR_W'(MEM_BYTES - 4);

        logic              d_active;
        logic              d_range_err;
        logic              d_prot_err;
        logic              user_mode;
        logic [ADDR_W-1:0] limit_ext;

        assign d_active  = i_dreq.rd_en | i_dreq.wr_en;
        assign user_mode = (i_cpsr_mode == MODE_USR);
        assign limit_ext = ADDR_W'(i_cfg.prot_limit);

        // Word would run past the end of the store.
        assign d_range_err = (i_dreq.addr > LAST_WORD);

        // User code may not touch the protected low region.
        assign d_prot_err = user_mode && (i_dreq.addr < limit_ext);

        assign o_dabort = d_active && (d_range_err || d_prot_err);

        // Fetches check range only; user code runs from protected space.
        assign o_iabort = (i_iaddr > LAST_WORD);

endmodule

//--- hw/stall_gen.sv
`timescale 1ns/1ps

module stall_gen
        import mem_pkg::*;
(
        input  logic     i_clk,
        input  logic     i_rst_n,
        input  mem_cfg_t i_cfg,

        output logic     o_miss,       // Data miss strobe.
        output logic     o_hit1        // Instruction hit strobe.
);

        logic [LFSR_W-1:0] lfsr;
        logic [LFSR_W-1:0] lfsr_next;
        logic              feedback;
        logic              miss_next;
        logic              hit1_next;

        // Taps 16, 14, 13, 11.
        assign feedback = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

        always_comb
        begin
                lfsr_next = lfsr;
                if (i_cfg.seed_load)
                begin
                        lfsr_next = i_cfg.seed;
                end
                else if (i_cfg.stall_en)
                begin
                        lfsr_next = {lfsr[LFSR_W-2:0], feedback};
                end
        end

        // Strobes compare the new state against the thresholds.
        always_comb
        begin
                miss_next = 1'b0;
                hit1_next = 1'b1;
                if (i_cfg.stall_en)
                begin
                        miss_next = (lfsr_next[7:0] < i_cfg.miss_thresh);
                        hit1_next = !(lfsr_next[15:8] < i_cfg.imiss_thresh);
                end
        end

        always_ff @(posedge i_clk or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        lfsr   <= DEFAULT_SEED;
                        o_miss <= 1'b1;      // Cold cache out of reset.
                        o_hit1 <= 1'b0;
                end
                else
                begin
                        lfsr   <= lfsr_next;
                        o_miss <= miss_next;
                        o_hit1 <= hit1_next;
                end
        end

endmodule

//--- hw/mem_cfg_regs.sv
`timescale 1ns/1ps

module mem_cfg_regs
        import mem_pkg::*;
(
        input  logic              i_clk,
        input  logic              i_rst_n,

        input  logic              i_cfg_we,
        input  logic [1:0]        i_cfg_addr,
        input  logic [DATA_W-1:0] i_cfg_wdata,
        output logic [DATA_W-1:0] o_cfg_rdata,

        output mem_cfg_t          o_cfg
);

        logic              stall_en;
        logic [MEM_AW-1:0] prot_limit;
        logic [7:0]        miss_thresh;
        logic [7:0]        imiss_thresh;
        logic [LFSR_W-1:0] seed;
        logic              seed_load;

        always_ff @(posedge i_clk or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        stall_en     <= 1'b0;
                        prot_limit   <= DEFAULT_LIMIT;
                        miss_thresh  <= '0;
                        imiss_thresh <= '0;
                        seed         <= DEFAULT_SEED;
                        seed_load    <= 1'b0;
                end
                else
                begin
                        // Pulse follows the SEED write by one edge.
                        seed_load <= i_cfg_we && (i_cfg_addr == CFG_SEED);
                        if (i_cfg_we)
                        begin
                                case (i_cfg_addr)
                                        CFG_CTRL:   stall_en   <= i_cfg_wdata[0];
                                        CFG_LIMIT:  prot_limit <= i_cfg_wdata[MEM_AW-1:0];
                                        CFG_THRESH:
                                        begin
                                                miss_thresh  <= i_cfg_wdata[7:0];
                                                imiss_thresh <= i_cfg_wdata[15:8];
                                        end
                                        default:    seed <= i_cfg_wdata[LFSR_W-1:0];
                                endcase
                        end
                end
        end

        // Unused bits read back as zero.
        always_comb
        begin
                case (i_cfg_addr)
                        CFG_CTRL:   o_cfg_rdata = DATA_W'(stall_en);
                        CFG_LIMIT:  o_cfg_rdata = DATA_W'(prot_limit);
                        CFG_THRESH: o_cfg_rdata = DATA_W'({imiss_thresh, miss_thresh});
                        default:    o_cfg_rdata = DATA_W'(seed);
                endcase
        end

        assign o_cfg = '{stall_en:     stall_en,
                         prot_limit:   prot_limit,
                         miss_thresh:  miss_thresh,
                         imiss_thresh: imiss_thresh,
                         seed:         seed,
                         seed_load:    seed_load};

endmodule

//--- hw/mem_subsys.sv
`timescale 1ns/1ps

module mem_subsys
        import mem_pkg::*;
(
        input  logic              i_clk,
        input  logic              i_rst_n,

        input  data_req_t         i_dreq,
        input  logic [ADDR_W-1:0] i_iaddr,
        input  logic [4:0]        i_cpsr_mode,

        // Configuration port.
        input  logic              i_cfg_we,
        input  logic [1:0]        i_cfg_addr,
        input  logic [DATA_W-1:0] i_cfg_wdata,
        output logic [DATA_W-1:0] o_cfg_rdata,

        output logic [DATA_W-1:0] o_rdata,
        output logic [DATA_W-1:0] o_idata,
        output logic              o_dabort,
        output logic              o_iabort,
        output logic              o_miss,
        output logic              o_hit1
);

        mem_cfg_t          cfg;
        logic [DATA_W-1:0] ram_rdata;
        logic [DATA_W-1:0] ram_idata;
        logic              ram_we;

        // Aborted writes never reach the store.
        assign ram_we = i_dreq.wr_en && !o_dabort;

        mem_cfg_regs u_cfg_regs (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_cfg_we    (i_cfg_we),
                .i_cfg_addr  (i_cfg_addr),
                .i_cfg_wdata (i_cfg_wdata),
                .o_cfg_rdata (o_cfg_rdata),
                .o_cfg       (cfg)
        );

        access_guard u_guard (
                .i_dreq      (i_dreq),
                .i_iaddr     (i_iaddr),
                .i_cpsr_mode (i_cpsr_mode),
                .i_cfg       (cfg),
                .o_dabort    (o_dabort),
                .o_iabort    (o_iabort)
        );

        unified_ram u_ram (
                .i_clk   (i_clk),
                .i_we    (ram_we),
                .i_daddr (i_dreq.addr[MEM_AW-1:0]),
                .i_wdata (i_dreq.wdata),
                .i_rd_en (i_dreq.rd_en | i_dreq.wr_en),  // Idle port reads zero.
                .i_iaddr (i_iaddr[MEM_AW-1:0]),
                .o_rdata (ram_rdata),
                .o_idata (ram_idata)
        );

        stall_gen u_stall (
                .i_clk   (i_clk),
                .i_rst_n (i_rst_n),
                .i_cfg   (cfg),
                .o_miss  (o_miss),
                .o_hit1  (o_hit1)
        );

        // Aborted reads return zero.
        assign o_rdata = o_dabort ? '0 : ram_rdata;
        assign o_idata = o_iabort ? '0 : ram_idata;

endmodule

//--- tests/tb_mem_subsys.sv
`timescale 1ns/1ps

module tb_mem_subsys
        import mem_pkg::*;
();

        localparam logic [31:0] LAST_WORD       = 32'(MEM_BYTES - 4);
        localparam logic [4:0]  MODE_SVC        = 5'b10011;
        localparam int          WATCHDOG_CYCLES = 20000;

        logic        i_clk;
        logic        i_rst_n;
        data_req_t   dreq;
        logic [31:0] iaddr;
        logic [4:0]  cpsr_mode;
        logic        cfg_we;
        logic [1:0]  cfg_addr;
        logic [31:0] cfg_wdata;
        logic [31:0] cfg_rdata;
        logic [31:0] rdata;
        logic [31:0] idata;
        logic        dabort;
        logic        iabort;
        logic        miss;
        logic        hit1;

        // Reference state.
        logic [7:0]  model_mem [MEM_BYTES];
        logic [31:0] model_limit;
        logic [15:0] model_lfsr;
        logic [31:0] written_addrs [$];

        mem_subsys i_mem_subsys (
                .i_clk       (i_clk),
                .i_rst_n     (i_rst_n),
                .i_dreq      (dreq),
                .i_iaddr     (iaddr),
                .i_cpsr_mode (cpsr_mode),
                .i_cfg_we    (cfg_we),
                .i_cfg_addr  (cfg_addr),
                .i_cfg_wdata (cfg_wdata),
                .o_cfg_rdata (cfg_rdata),
                .o_rdata     (rdata),
                .o_idata     (idata),
                .o_dabort    (dabort),
                .o_iabort    (iabort),
                .o_miss      (miss),
                .o_hit1      (hit1)
        );

        initial
        begin
                i_clk = 1'b0;
                forever #5 i_clk = ~i_clk;
        end

        initial
        begin
                for (int c = 0; c < WATCHDOG_CYCLES; c++)
                begin
                        @(posedge i_clk);
                end
                stop_run("Simulation ran past its cycle budget without finishing");
        end

        task automatic stop_run(input string why);
                $display("%s", why);
                $display("Regression failed");
                $fatal(1);
        endtask

        task automatic report_mismatch(input string name, input logic [31:0] exp,
                                       input logic [31:0] act);
                stop_run($sformatf("Mismatch %s: expected %h, actual %h", name, exp, act));
        endtask

        task automatic check_value(input string name, input logic [31:0] exp,
                                   input logic [31:0] act);
                assert (act === exp)
                else report_mismatch(name, exp, act);
        endtask

        // Cold-cache strobes while reset is held.
        assert property (@(posedge i_clk) !i_rst_n |-> (miss && !hit1))
        else report_mismatch("reset_strobes", 32'h2, {30'h0, miss, hit1});

        assert property (@(negedge i_clk) disable iff (!i_rst_n)
                (!dreq.rd_en && !dreq.wr_en) |-> (rdata == '0))
        else report_mismatch("idle_read_zero", 32'h0, rdata);

        // Any enabled access past the last full word aborts.
        assert property (@(negedge i_clk) disable iff (!i_rst_n)
                ((dreq.rd_en || dreq.wr_en) && (dreq.addr > LAST_WORD)) |-> dabort)
        else report_mismatch("range_dabort", 32'h1, 32'(dabort));

        function automatic logic [31:0] model_word(input logic [31:0] addr);
                logic [31:0] w;
                for (int b = 0; b < 4; b++)
                begin
                        w[8*b +: 8] = model_mem[MEM_AW'(addr + 32'(b))];  // Little-endian.
                end
                return w;
        endfunction

        function automatic logic expect_dabort(input logic [31:0] addr, input logic rd,
                                               input logic wr);
                logic prot;
                prot = (cpsr_mode == MODE_USR) && (addr < model_limit);
                return (rd || wr) && ((addr > LAST_WORD) || prot);
        endfunction

        // Fibonacci x^16 + x^14 + x^13 + x^11 + 1 that shifts toward the MSB.
        function automatic logic [15:0] lfsr_step(input logic [15:0] s);
                return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
        endfunction

        function automatic logic [31:0] reg_mask(input logic [1:0] sel);
                case (sel)
                        CFG_CTRL:   return 32'h0000_0001;
                        CFG_LIMIT:  return 32'h0000_1FFF;
                        default:    return 32'h0000_FFFF;
                endcase
        endfunction

        task automatic next_cycle();
                @(posedge i_clk);
                #1;
        endtask

        task automatic data_access(input string name, input logic [31:0] addr,
                                   input logic [31:0] wdata, input logic rd, input logic wr);
                logic        abort;
                logic [31:0] exp_rdata;
                next_cycle();
                dreq.addr  = addr;
                dreq.wdata = wdata;
                dreq.rd_en = rd;
                dreq.wr_en = wr;
                abort      = expect_dabort(addr, rd, wr);
                exp_rdata  = (abort || !rd) ? 32'h0 : model_word(addr);
                @(negedge i_clk);
                check_value({name, " dabort"}, 32'(abort), 32'(dabort));
                if (rd || !wr)
                begin
                        check_value({name, " rdata"}, exp_rdata, rdata);
                end
                if (wr && !abort)
                begin
                        for (int b = 0; b < 4; b++)
                        begin
                                model_mem[MEM_AW'(addr + 32'(b))] = wdata[8*b +: 8];
                        end
                end
                next_cycle();                   // Write lands on this edge.
                dreq.rd_en = 1'b0;
                dreq.wr_en = 1'b0;
        endtask

        task automatic fetch_check(input string name, input logic [31:0] addr);
                logic abort;
                next_cycle();
                iaddr = addr;
                abort = (addr > LAST_WORD);
                @(negedge i_clk);
                check_value({name, " iabort"}, 32'(abort), 32'(iabort));
                check_value({name, " idata"}, abort ? 32'h0 : model_word(addr), idata);
        endtask

        task automatic cfg_write(input logic [1:0] addr, input logic [31:0] data);
                next_cycle();
                cfg_we    = 1'b1;
                cfg_addr  = addr;
                cfg_wdata = data;
                next_cycle();
                cfg_we = 1'b0;
                if (addr == CFG_LIMIT)
                begin
                        model_limit = 32'(data[MEM_AW-1:0]);
                end
        endtask

        task automatic cfg_read_check(input string name, input logic [1:0] addr,
                                      input logic [31:0] exp);
                next_cycle();
                cfg_addr = addr;
                @(negedge i_clk);
                check_value(name, exp, cfg_rdata);
        endtask

        task automatic wait_strobes_idle();
                logic idle;
                idle = 1'b0;
                for (int c = 0; c < 8; c++)
                begin
                        @(negedge i_clk);
                        if (!miss && hit1)
                        begin
                                idle = 1'b1;
                                break;
                        end
                end
                if (!idle)
                begin
                        stop_run("Timed out waiting for the strobes to go idle");
                end
        endtask

        initial
        begin
                logic [31:0] addr;
                logic [31:0] data;
                logic [7:0]  miss_th;
                logic [7:0]  imiss_th;
                logic [1:0]  reg_sel;

                void'($urandom(32'h9063));
                i_rst_n     = 1'b1;
                dreq        = '0;
                iaddr       = '0;
                cpsr_mode   = MODE_SVC;
                cfg_we      = 1'b0;
                cfg_addr    = CFG_CTRL;
                cfg_wdata   = '0;
                model_limit = 32'(DEFAULT_LIMIT);

                #1 i_rst_n = 1'b0;
                for (int c = 0; c < 5; c++)
                begin
                        @(negedge i_clk);
                        check_value("reset_strobes", 32'h2, {30'h0, miss, hit1});
                end
                @(posedge i_clk);
                #1 i_rst_n = 1'b1;

                cfg_read_check("rst_ctrl", CFG_CTRL, 32'h0);
                cfg_read_check("rst_limit", CFG_LIMIT, 32'(DEFAULT_LIMIT));
                cfg_read_check("rst_thresh", CFG_THRESH, 32'h0);
                cfg_read_check("rst_seed", CFG_SEED, 32'(DEFAULT_SEED));

                // Half of the privileged random words are word-aligned.
                for (int n = 0; n < 24; n++)
                begin
                        addr = $urandom % (MEM_BYTES - 3);
                        if (n % 2 == 0)
                        begin
                                addr = addr & ~32'h3;
                        end
                        data = $urandom;
                        data_access("wr_word", addr, data, 1'b0, 1'b1);
                        data_access("rd_word", addr, 32'h0, 1'b1, 1'b0);
                        fetch_check("fetch_word", addr);
                        written_addrs.push_back(addr);
                end
                foreach (written_addrs[k])
                begin
                        data_access("reread", written_addrs[k], 32'h0, 1'b1, 1'b0);
                end
                data_access("idle_read", 32'h40, 32'h0, 1'b0, 1'b0);

                data_access("wr_low", 32'h10, 32'hA5A5_5A5A, 1'b0, 1'b1);
                data_access("wr_top", LAST_WORD, $urandom, 1'b0, 1'b1);
                data_access("range_rd", 32'(MEM_BYTES - 3), 32'h0, 1'b1, 1'b0);
                data_access("range_rd", 32'h0001_0000, 32'h0, 1'b1, 1'b0);
                data_access("range_rd", 32'hFFFF_FFFC, 32'h0, 1'b1, 1'b0);
                data_access("range_wr", 32'(MEM_BYTES) + 32'h10, 32'h1234_5678, 1'b0, 1'b1);
                data_access("range_idle", 32'(MEM_BYTES - 1), 32'h0, 1'b0, 1'b0);
                data_access("alias_rd", 32'h10, 32'h0, 1'b1, 1'b0);   // Store index 0x10 untouched.
                data_access("top_rd", LAST_WORD, 32'h0, 1'b1, 1'b0);
                fetch_check("top_fetch", LAST_WORD);
                fetch_check("range_fetch", 32'(MEM_BYTES - 3));
                fetch_check("range_fetch", 32'h8000_0000);

                // Known words on both sides of the two limits.
                data_access("prep", 32'h100, $urandom, 1'b0, 1'b1);
                data_access("prep", 32'h3FC, $urandom, 1'b0, 1'b1);
                data_access("prep", 32'h400, $urandom, 1'b0, 1'b1);
                data_access("prep", 32'h7FC, $urandom, 1'b0, 1'b1);
                data_access("prep", 32'h800, $urandom, 1'b0, 1'b1);
                cpsr_mode = MODE_USR;
                data_access("usr_rd_low", 32'h3FC, 32'h0, 1'b1, 1'b0);
                data_access("usr_wr_low", 32'h100, 32'hDEAD_BEEF, 1'b0, 1'b1);
                data_access("usr_rd_limit", 32'h400, 32'h0, 1'b1, 1'b0);
                data_access("usr_wr_high", 32'h405, $urandom, 1'b0, 1'b1);
                data_access("usr_rd_high", 32'h405, 32'h0, 1'b1, 1'b0);
                fetch_check("usr_fetch_low", 32'h100);
                cfg_write(CFG_LIMIT, 32'h800);
                cfg_read_check("limit_rb", CFG_LIMIT, 32'h800);
                data_access("usr_rd_old", 32'h400, 32'h0, 1'b1, 1'b0);
                data_access("usr_rd_old", 32'h7FC, 32'h0, 1'b1, 1'b0);
                data_access("usr_rd_new", 32'h800, 32'h0, 1'b1, 1'b0);
                fetch_check("usr_fetch_low", 32'h400);
                cpsr_mode = MODE_SVC;
                data_access("svc_rd_low", 32'h100, 32'h0, 1'b1, 1'b0);

                miss_th  = 8'h60;
                imiss_th = 8'hA0;
                cfg_write(CFG_SEED, 32'h0000_5A3C);
                cfg_write(CFG_THRESH, {16'h0, imiss_th, miss_th});
                @(negedge i_clk);
                check_value("stall_off", 32'h1, {30'h0, miss, hit1});
                cfg_write(CFG_CTRL, 32'h1);
                model_lfsr = 16'h5A3C;              // Loaded while stall_en was low.
                for (int n = 0; n < 48; n++)
                begin
                        @(posedge i_clk);
                        model_lfsr = lfsr_step(model_lfsr);
                        @(negedge i_clk);
                        check_value("miss", 32'(model_lfsr[7:0] < miss_th), 32'(miss));
                        check_value("hit1", 32'(!(model_lfsr[15:8] < imiss_th)), 32'(hit1));
                end
                cfg_write(CFG_CTRL, 32'h0);
                wait_strobes_idle();
                for (int n = 0; n < 4; n++)
                begin
                        @(negedge i_clk);
                        check_value("stall_off", 32'h1, {30'h0, miss, hit1});
                end

                for (int n = 0; n < 16; n++)
                begin
                        data    = $urandom;
                        reg_sel = 2'($urandom % 4);
                        cfg_write(reg_sel, data);
                        cfg_read_check("cfg_rb", reg_sel, data & reg_mask(reg_sel));
                end

                $display("Regression passed");
                $finish;
        end

endmodule

//--- sim.f
hw/mem_pkg.sv
hw/unified_ram.sv
hw/access_guard.sv
hw/stall_gen.sv
hw/mem_cfg_regs.sv
hw/mem_subsys.sv
tests/tb_mem_subsys.sv

//--- Bender.yml
package:
  name: mem_subsys

sources:
  - files:
      - hw/mem_pkg.sv
      - hw/unified_ram.sv
      - hw/access_guard.sv
      - hw/stall_gen.sv
      - hw/mem_cfg_regs.sv
      - hw/mem_subsys.sv
  - target: test
    files:
      - tests/tb_mem_subsys.sv
